// File: uart_pkg.sv
package uart_pkg;

	// --------------------
	// Bit timing
	// --------------------
	localparam int CLKS_PER_BIT = 16;                   // Oversampling ratio, clocks per serial bit
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;     // Start bit confirm point
	localparam int CNT_W        = $clog2(CLKS_PER_BIT); // Width of the in-bit clock counter

	// --------------------
	// Frame format
	// --------------------
	localparam int DATA_BITS = 8;                 // Data bits per frame, LSB first
	localparam int BIT_IDX_W = $clog2(DATA_BITS); // Data bit index width

	// Receiver FSM states
	typedef enum logic [1:0] {
		RX_IDLE,  // Line high, waiting for falling edge
		RX_START, // Confirming start bit at half period
		RX_DATA,  // Sampling data bits at mid-bit
		RX_STOP   // Sampling stop bit
	} rx_state_t;

	// One received byte plus its framing status
	typedef struct packed {
		logic                 frame_err; // Stop bit sampled low
		logic [DATA_BITS-1:0] data;      // Received data, bit 0 first on the line
	} rx_byte_t;

endpackage

// File: word_pkg.sv
package word_pkg;

	// --------------------
	// Word geometry
	// --------------------
	localparam int BYTES_PER_WORD = 4; // Bytes packed into one word
	localparam int WORD_W = BYTES_PER_WORD * uart_pkg::DATA_BITS; // 32 bits
	localparam int LANE_W = $clog2(BYTES_PER_WORD); // Lane index width

	// --------------------
	// Buffering
	// --------------------
	localparam int BYTE_FIFO_DEPTH = 4; // Received bytes waiting for the assembler
	localparam int WORD_FIFO_DEPTH = 4; // Finished words waiting for the consumer

	// Assembled word, first byte in bits 7:0
	typedef logic [WORD_W-1:0] word_t;

	// Byte slot currently being filled
	typedef logic [LANE_W-1:0] lane_t;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
	input  logic               clk,
	input  logic               rst,
	input  logic               rx,       // Serial line, idle high
	output logic               byte_stb, // One cycle at mid stop bit
	output uart_pkg::rx_byte_t byte_out
);

	logic rx_meta; // First synchronizer stage
	logic rx_sync; // Safe to use in the FSM

	uart_pkg::rx_state_t               state;
	logic [uart_pkg::CNT_W-1:0]        clk_cnt;  // Clocks inside current bit
	logic [uart_pkg::BIT_IDX_W-1:0]    bit_idx;  // Data bit being sampled
	logic [uart_pkg::DATA_BITS-1:0]    shreg;    // Incoming data, shifted from the top
	logic                              stop_low; // Bad stop seen, waiting out the bit

	logic half_tick; // Half a bit period elapsed
	logic bit_tick;  // Full bit period elapsed

	assign half_tick = (clk_cnt == uart_pkg::CNT_W'(uart_pkg::HALF_BIT - 1));
	assign bit_tick  = (clk_cnt == uart_pkg::CNT_W'(uart_pkg::CLKS_PER_BIT - 1));

	// --------------------
	// Input synchronizer
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1; // Line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// --------------------
	// Frame FSM
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= uart_pkg::RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			stop_low <= 1'b0;
			byte_stb <= 1'b0;
		end else begin
			byte_stb <= 1'b0; // Strobe lasts a single cycle
			case (state)
				uart_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= uart_pkg::RX_START; // Falling edge
				end
				uart_pkg::RX_START: begin
					if (half_tick) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// Line back high means a glitch, not a start bit
						state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_DATA: begin
					if (bit_tick) begin // Mid-bit sample point
						clk_cnt <= '0;
						if (bit_idx == uart_pkg::BIT_IDX_W'(uart_pkg::DATA_BITS - 1))
							state <= uart_pkg::RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_STOP: begin
					if (stop_low) begin
						// Sit out the rest of a low stop bit so the next
						// start edge lines up again
						if (half_tick) begin
							stop_low <= 1'b0;
							state    <= uart_pkg::RX_IDLE;
						end else begin
							clk_cnt <= clk_cnt + 1'b1;
						end
					end else if (bit_tick) begin
						byte_stb <= 1'b1; // Byte goes out either way
						clk_cnt  <= '0;
						if (rx_sync)
							state <= uart_pkg::RX_IDLE;
						else
							stop_low <= 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// --------------------
	// Data path
	// --------------------
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && bit_tick)
			shreg <= {rx_sync, shreg[uart_pkg::DATA_BITS-1:1]}; // LSB arrives first
		if (state == uart_pkg::RX_STOP && bit_tick && !stop_low) begin
			byte_out.data      <= shreg;
			byte_out.frame_err <= ~rx_sync; // Stop must be high
		end
	end

endmodule

// File: sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4 // Power of two
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,      // Oldest entry, valid with not_empty
	output logic     not_empty,
	output logic     full,
	output logic     overrun    // Sticky, push was refused
);

	payload_t mem [DEPTH];

	// Extra top bit tells full from empty
	logic [$clog2(DEPTH):0] wr_ptr;
	logic [$clog2(DEPTH):0] rd_ptr;

	logic do_push;
	logic do_pop;

	assign not_empty = (wr_ptr != rd_ptr);
	assign full      = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
	                   (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

	assign do_push = push && !full;     // Full FIFO drops the write
	assign do_pop  = pop  && not_empty; // Empty pop does nothing

	assign head = mem[rd_ptr[$clog2(DEPTH)-1:0]];

	// --------------------
	// Pointers and status
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			overrun <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && full)
				overrun <= 1'b1; // Held until reset
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[$clog2(DEPTH)-1:0]] <= push_data;
	end

endmodule

// File: word_assembler.sv
`timescale 1ns/1ns

module word_assembler (
	input  logic               clk,
	input  logic               rst,
	input  logic               byte_avail,  // Byte FIFO not empty
	input  uart_pkg::rx_byte_t byte_in,     // Byte FIFO head
	input  logic               word_room,   // Word FIFO not full
	output logic               byte_pop,
	output logic               word_push,
	output word_pkg::word_t    word_out,
	output logic               frame_error  // Partial word thrown away
);

	word_pkg::lane_t lane;     // Slot the next byte goes into
	word_pkg::word_t word_buf; // Bytes so far, newest at the top

	logic last_lane;
	logic bad_byte;

	// --------------------
	// Handshake
	// --------------------
	// Stall on a full word FIFO even mid-word, keeps things simple
	assign byte_pop  = byte_avail && word_room;
	assign bad_byte  = byte_in.frame_err;
	assign last_lane = (lane == word_pkg::lane_t'(word_pkg::BYTES_PER_WORD - 1));

	// Fourth byte pushes in the same edge it is popped
	assign word_push = byte_pop && !bad_byte && last_lane;

	// Earlier bytes already moved down, lane 0 ends in bits 7:0
	assign word_out = {byte_in.data,
	                   word_buf[word_pkg::WORD_W-1:uart_pkg::DATA_BITS]};

	// --------------------
	// Lane counter
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane        <= '0;
			frame_error <= 1'b0;
		end else begin
			frame_error <= byte_pop && bad_byte; // One cycle per discard
			if (byte_pop) begin
				if (bad_byte || last_lane)
					lane <= '0; // Restart at byte 0
				else
					lane <= lane + 1'b1;
			end
		end
	end

	// Shift register
	always_ff @(posedge clk) begin
		if (byte_pop) begin
			if (bad_byte)
				word_buf <= '0; // Drop partial word, bad byte not kept
			else
				word_buf <= {byte_in.data,
				             word_buf[word_pkg::WORD_W-1:uart_pkg::DATA_BITS]};
		end
	end

endmodule

// File: serial_word_rx.sv
`timescale 1ns/1ns

module serial_word_rx (
	input  logic            clk,
	input  logic            rst,
	input  logic            rx,          // Serial in, idle high
	input  logic            rd,          // Read strobe for out_word
	output logic            out_valid,   // Word waiting
	output word_pkg::word_t out_word,
	output logic            frame_error, // Pulse per discarded word
	output logic            overrun      // Sticky byte loss
);

	// --------------------
	// Byte path
	// --------------------
	logic               byte_stb;
	uart_pkg::rx_byte_t rx_byte;
	uart_pkg::rx_byte_t byte_head;
	logic               byte_avail;
	logic               byte_pop;

	// --------------------
	// Word path
	// --------------------
	logic            word_push;
	word_pkg::word_t word_in;
	logic            word_full;
	logic            word_room;

	assign word_room = !word_full;

	uart_rx u_rx (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.byte_stb (byte_stb),
		.byte_out (rx_byte)
	);

	// Full is only acted on inside the FIFO, which refuses the write
	sync_fifo #(
		.payload_t (uart_pkg::rx_byte_t),
		.DEPTH     (word_pkg::BYTE_FIFO_DEPTH)
	) u_byte_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (byte_stb), // Strobe goes straight in
		.push_data (rx_byte),
		.pop       (byte_pop),
		.head      (byte_head),
		.not_empty (byte_avail),
		.full      (),
		.overrun   (overrun)
	);

	word_assembler u_asm (
		.clk         (clk),
		.rst         (rst),
		.byte_avail  (byte_avail),
		.byte_in     (byte_head),
		.word_room   (word_room),
		.byte_pop    (byte_pop),
		.word_push   (word_push),
		.word_out    (word_in),
		.frame_error (frame_error)
	);

	// Assembler never pushes when full, overrun unused here
	sync_fifo #(
		.payload_t (word_pkg::word_t),
		.DEPTH     (word_pkg::WORD_FIFO_DEPTH)
	) u_word_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (word_push),
		.push_data (word_in),
		.pop       (rd),
		.head      (out_word),
		.not_empty (out_valid),
		.full      (word_full),
		.overrun   ()
	);

endmodule

// File: serial_word_rx_sva.sv
`timescale 1ns/1ns

module serial_word_rx_sva #(
	parameter bit FIFO_SIDE = 1'b0, // Set when bound into a FIFO
	parameter bit WORD_FIFO = 1'b0  // FIFO side only, set for the word FIFO
) (
	input logic clk,
	input logic rst,
	input logic pop,   // Pop strobe
	input logic avail, // Data present in the FIFO being popped
	input logic push,  // Push strobe
	input logic room,  // Space in the FIFO being pushed
	input logic flag   // frame_error or overrun
);

	// --------------------
	// Assembler side
	// --------------------
	if (!FIFO_SIDE) begin : g_asm
		a_err_pulse: assert property (@(posedge clk) disable iff (rst) flag |=> !flag)
			else $error("frame_error longer than one cycle");
		// Reset has had a full cycle to settle
		a_rst_quiet: assert property (@(posedge clk)
			rst && $past(rst) |-> !pop && !push && !flag && !avail && room)
			else $error("assembler strobe active in reset");
	end else begin : g_fifo
		if (WORD_FIFO) begin : g_word
			// Assembler stalls while the word FIFO is full
			a_push_room: assert property (@(posedge clk) disable iff (rst) push |-> room)
				else $error("word push into full word FIFO");
		end else begin : g_byte
			// Never pop an empty byte FIFO
			a_pop_avail: assert property (@(posedge clk) disable iff (rst) pop |-> avail)
				else $error("pop while byte FIFO empty");
		end
		a_rst_idle: assert property (@(posedge clk)
			rst && $past(rst) |-> !push && !pop && !avail && !flag)
			else $error("FIFO strobe or status active in reset");
	end

endmodule

bind word_assembler serial_word_rx_sva #(.FIFO_SIDE(1'b0)) u_asm_sva (
	.clk(clk), .rst(rst), .pop(byte_pop), .avail(byte_avail),
	.push(word_push), .room(word_room), .flag(frame_error)
);

bind sync_fifo serial_word_rx_sva #(
	.FIFO_SIDE (1'b1),
	.WORD_FIFO ($bits(payload_t) == word_pkg::WORD_W) // Told apart by payload width
) u_fifo_sva (
	.clk(clk), .rst(rst), .pop(pop), .avail(not_empty),
	.push(push), .room(!full), .flag(overrun)
);

// File: tb_serial_word_rx.sv
`timescale 1ns/1ns

module tb_serial_word_rx;

	localparam int BIT_CLKS   = uart_pkg::CLKS_PER_BIT;
	localparam int FRAME_CLKS = BIT_CLKS * (uart_pkg::DATA_BITS + 2); // Start, data, stop
	localparam int N_ROWS     = 9;
	localparam int OVR_WORDS  = word_pkg::WORD_FIFO_DEPTH + 3; // Enough to lose bytes
	localparam logic [2:0] NO_BAD = 3'd4; // No lane has a bad stop

	// One stimulus row, name kept in row_names
	typedef struct packed {
		word_pkg::word_t data;      // Byte 0 in bits 7:0
		logic            rand_fill; // First word from the LFSR too
		logic [2:0]      bad_lane;  // Lane with a low stop bit
		logic [3:0]      reps;      // Words sent before reading
	} row_t;

	logic            clk;
	logic            rst;
	logic            rx;
	logic            rd;
	logic            out_valid;
	word_pkg::word_t out_word;
	logic            frame_error;
	logic            overrun;

	row_t  rows [N_ROWS];
	string row_names [N_ROWS];

	word_pkg::word_t exp_q [$]; // Model output, oldest first
	word_pkg::word_t part_word; // Model partial word
	int              part_lane;
	int              exp_errs;  // Expected discard pulses
	int              err_seen;  // Pulses seen on the DUT
	logic [31:0]     lfsr;

	serial_word_rx UUT (
		.clk         (clk),
		.rst         (rst),
		.rx          (rx),
		.rd          (rd),
		.out_valid   (out_valid),
		.out_word    (out_word),
		.frame_error (frame_error),
		.overrun     (overrun)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk or posedge rst) begin
		if (rst)
			err_seen <= 0;
		else if (frame_error)
			err_seen <= err_seen + 1; // One per discarded word
	end

	// --------------------
	// Checking
	// --------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output word_pkg::word_t w);
		for (int i = 0; i < word_pkg::WORD_W; i++) begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0]; // One step per bit
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic wait_clks(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// --------------------
	// Serial driver
	// --------------------
	task automatic drive_bit(input logic b);
		rx = b;
		wait_clks(BIT_CLKS);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic bad_stop);
		drive_bit(1'b0); // Start
		for (int i = 0; i < uart_pkg::DATA_BITS; i++)
			drive_bit(data[i]); // LSB first
		drive_bit(!bad_stop);
		if (bad_stop)
			drive_bit(1'b1); // Idle bit, receiver realigns
	endtask

	// Packing rule, byte n at bits 8n+7:8n
	task automatic model_byte(input logic [7:0] data, input logic bad);
		if (bad) begin
			part_word = '0; // Partial word thrown away
			part_lane = 0;
			exp_errs++;
		end else begin
			part_word[part_lane*uart_pkg::DATA_BITS +: uart_pkg::DATA_BITS] = data;
			if (part_lane == word_pkg::BYTES_PER_WORD - 1) begin
				exp_q.push_back(part_word);
				part_word = '0;
				part_lane = 0;
			end else begin
				part_lane++;
			end
		end
	endtask

	// Stops after a bad byte
	task automatic send_word(input word_pkg::word_t w, input logic [2:0] bad_lane);
		logic [7:0] b;
		logic       bad;
		int         lane;
		lane = 0;
		bad  = 1'b0;
		while (lane < word_pkg::BYTES_PER_WORD && !bad) begin
			b   = w[lane*uart_pkg::DATA_BITS +: uart_pkg::DATA_BITS];
			bad = (lane == int'(bad_lane));
			send_frame(b, bad);
			model_byte(b, bad);
			lane++;
		end
	endtask

	// --------------------
	// Word reader
	// --------------------
	task automatic pulse_rd();
		rd = 1'b1;
		wait_clks(1);
		rd = 1'b0;
	endtask

	task automatic wait_valid(input int max_clks);
		int n;
		n = 0;
		while (!out_valid && n < max_clks) begin
			wait_clks(1);
			n++;
		end
	endtask

	task automatic read_word(input string name, input word_pkg::word_t expected);
		wait_valid(2 * FRAME_CLKS);
		if (!out_valid) begin
			abort_run($sformatf("timeout waiting for a word in %s", name));
		end else begin
			check(name, expected, out_word);
			pulse_rd();
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		rx  = 1'b1; // Idle line
		rd  = 1'b0;
		part_word = '0;
		part_lane = 0;
		exp_errs  = 0;
		exp_q.delete();
		wait_clks(5);
		rst = 1'b0;
	endtask

	task automatic load_table();
		rows[0] = '{32'h44332211, 1'b0, NO_BAD, 4'd1};
		row_names[0] = "single_word";
		rows[1] = '{32'hdeadbeef, 1'b0, NO_BAD, 4'd3};
		row_names[1] = "back_to_back";
		rows[2] = '{32'h0, 1'b1, NO_BAD, 4'd2};
		row_names[2] = "lfsr_pair";
		rows[3] = '{32'h0000aa55, 1'b0, 3'd1, 4'd1};
		row_names[3] = "bad_lane1";
		rows[4] = '{32'h87654321, 1'b0, NO_BAD, 4'd1};
		row_names[4] = "after_bad1";
		rows[5] = '{32'h13579bdf, 1'b0, 3'd3, 4'd1};
		row_names[5] = "bad_lane3";
		rows[6] = '{32'h0, 1'b1, NO_BAD, 4'd1};
		row_names[6] = "after_bad3";
		rows[7] = '{32'h000000ff, 1'b0, 3'd0, 4'd1};
		row_names[7] = "bad_lane0";
		// Word FIFO plus one word parked in the byte FIFO
		rows[8] = '{32'h0, 1'b1, NO_BAD, 4'(word_pkg::WORD_FIFO_DEPTH +
		            word_pkg::BYTE_FIFO_DEPTH / word_pkg::BYTES_PER_WORD)};
		row_names[8] = "fill_no_loss";
	endtask

	task automatic run_row(input int r);
		word_pkg::word_t w;
		for (int k = 0; k < int'(rows[r].reps); k++) begin
			if (k == 0 && !rows[r].rand_fill)
				w = rows[r].data;
			else
				rand_word(w);
			send_word(w, (k == 0) ? rows[r].bad_lane : NO_BAD);
		end
		wait_clks(4); // Last byte through the assembler
		check({row_names[r], "_errs"}, exp_errs, err_seen);
		while (exp_q.size() > 0)
			read_word(row_names[r], exp_q.pop_front());
		wait_clks(4);
		check({row_names[r], "_drained"}, 32'd0, 32'(out_valid));
		check({row_names[r], "_overrun"}, 32'd0, 32'(overrun));
	endtask

	// Whole words lost once both FIFOs are full
	task automatic overrun_test();
		word_pkg::word_t sent [$];
		word_pkg::word_t w;
		int              idx;
		logic            more;
		for (int k = 0; k < OVR_WORDS; k++) begin
			rand_word(w);
			send_word(w, NO_BAD);
		end
		sent = exp_q;
		exp_q.delete();
		check("overrun_set", 32'd1, 32'(overrun));
		for (int k = 0; k < word_pkg::WORD_FIFO_DEPTH; k++)
			read_word("overrun_head", sent[k]);
		// Survivors continue the sent order
		idx  = word_pkg::WORD_FIFO_DEPTH;
		more = 1'b1;
		while (more) begin
			wait_valid(FRAME_CLKS);
			if (!out_valid) begin
				more = 1'b0;
			end else if (idx >= sent.size()) begin
				abort_run("more words came out than were sent");
			end else begin
				check("overrun_tail", sent[idx], out_word);
				pulse_rd();
				idx++;
			end
		end
		wait_clks(FRAME_CLKS);
		check("overrun_held", 32'd1, 32'(overrun));
		apply_reset();
		check("overrun_cleared", 32'd0, 32'(overrun));
		check("valid_cleared", 32'd0, 32'(out_valid));
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		rst  = 1'b1;
		rx   = 1'b1;
		rd   = 1'b0;
		lfsr = 32'h5370;
		load_table();
		apply_reset();
		check("reset_valid", 32'd0, 32'(out_valid));
		check("reset_frame_error", 32'd0, 32'(frame_error));
		check("reset_overrun", 32'd0, 32'(overrun));
		wait_clks(FRAME_CLKS); // Idle line
		rx = 1'b0;
		wait_clks(uart_pkg::HALF_BIT / 2); // Short of half a bit
		rx = 1'b1;
		wait_clks(FRAME_CLKS);
		check("glitch_valid", 32'd0, 32'(out_valid));
		check("glitch_errs", 32'd0, err_seen);
		check("glitch_overrun", 32'd0, 32'(overrun));
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		overrun_test();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: serial_word_rx.f
uart_pkg.sv
word_pkg.sv
uart_rx.sv
sync_fifo.sv
word_assembler.sv
serial_word_rx.sv
serial_word_rx_sva.sv
tb_serial_word_rx.sv

// File: Makefile
SRCS = $(shell cat serial_word_rx.f)

obj_dir/Vtb_serial_word_rx: serial_word_rx.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module tb_serial_word_rx -Mdir obj_dir -f serial_word_rx.f

.PHONY: run clean

run: obj_dir/Vtb_serial_word_rx
	./obj_dir/Vtb_serial_word_rx

clean:
	rm -rf obj_dir
